// ==== source/decode_pkg.sv ====
// RV32 only with 4 threads and 4 warps; no F extension, the four op_args views share 36 bits
package decode_pkg;

    localparam int UUID_BITS   = 8;
    localparam int NW_BITS     = 2;
    localparam int NUM_THREADS = 4;
    localparam int PC_BITS     = 30;
    localparam int NR_BITS     = 5;
    localparam int IMM_BITS    = 32;
    localparam int OP_BITS     = 4;

    // Major opcodes
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_L     = 7'b0000011;
    localparam logic [6:0] OPC_S     = 7'b0100011;
    localparam logic [6:0] OPC_FENCE = 7'b0001111;
    localparam logic [6:0] OPC_SYS   = 7'b1110011;
    localparam logic [6:0] OPC_EXT1  = 7'b0001011;

    localparam logic [6:0] F7_MUL = 7'b0000001;

    // Highest FPU CSR address
    localparam logic [11:0] CSR_FCSR = 12'h003;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    typedef enum logic [1:0] {
        ARITH  = 2'd0,
        BRANCH = 2'd1,
        MULDIV = 2'd2
    } alu_xtype_e;

    localparam logic [OP_BITS-1:0] ALU_ADD   = 4'd0;
    localparam logic [OP_BITS-1:0] ALU_SUB   = 4'd1;
    localparam logic [OP_BITS-1:0] ALU_SLL   = 4'd2;
    localparam logic [OP_BITS-1:0] ALU_SLT   = 4'd3;
    localparam logic [OP_BITS-1:0] ALU_SLTU  = 4'd4;
    localparam logic [OP_BITS-1:0] ALU_XOR   = 4'd5;
    localparam logic [OP_BITS-1:0] ALU_SRL   = 4'd6;
    localparam logic [OP_BITS-1:0] ALU_SRA   = 4'd7;
    localparam logic [OP_BITS-1:0] ALU_OR    = 4'd8;
    localparam logic [OP_BITS-1:0] ALU_AND   = 4'd9;
    localparam logic [OP_BITS-1:0] ALU_LUI   = 4'd10;
    localparam logic [OP_BITS-1:0] ALU_AUIPC = 4'd11;

    localparam logic [OP_BITS-1:0] BR_EQ     = 4'd0;
    localparam logic [OP_BITS-1:0] BR_NE     = 4'd1;
    localparam logic [OP_BITS-1:0] BR_LT     = 4'd2;
    localparam logic [OP_BITS-1:0] BR_GE     = 4'd3;
    localparam logic [OP_BITS-1:0] BR_LTU    = 4'd4;
    localparam logic [OP_BITS-1:0] BR_GEU    = 4'd5;
    localparam logic [OP_BITS-1:0] BR_JAL    = 4'd6;
    localparam logic [OP_BITS-1:0] BR_JALR   = 4'd7;
    localparam logic [OP_BITS-1:0] BR_ECALL  = 4'd8;
    localparam logic [OP_BITS-1:0] BR_EBREAK = 4'd9;
    localparam logic [OP_BITS-1:0] BR_URET   = 4'd10;
    localparam logic [OP_BITS-1:0] BR_SRET   = 4'd11;
    localparam logic [OP_BITS-1:0] BR_MRET   = 4'd12;

    localparam logic [OP_BITS-1:0] LSU_FENCE = 4'd15;

    // CSR ops take 1 to 3 straight from funct3
    localparam logic [OP_BITS-1:0] SFU_TMC    = 4'd4;
    localparam logic [OP_BITS-1:0] SFU_WSPAWN = 4'd5;
    localparam logic [OP_BITS-1:0] SFU_SPLIT  = 4'd6;
    localparam logic [OP_BITS-1:0] SFU_JOIN   = 4'd7;
    localparam logic [OP_BITS-1:0] SFU_BAR    = 4'd8;
    localparam logic [OP_BITS-1:0] SFU_PRED   = 4'd9;

    typedef struct packed {
        alu_xtype_e          xtype;
        logic                use_pc;
        logic                use_imm;
        logic [IMM_BITS-1:0] imm;
    } alu_args_t;

    typedef struct packed {
        logic        is_store;
        logic [11:0] offset;
        logic [22:0] pad;
    } lsu_args_t;

    typedef struct packed {
        logic [11:0] addr;
        logic        use_imm;
        logic [4:0]  imm;
        logic [17:0] pad;
    } csr_args_t;

    typedef struct packed {
        logic        is_neg;
        logic [34:0] pad;
    } wctl_args_t;

    typedef union packed {
        alu_args_t  alu;
        lsu_args_t  lsu;
        csr_args_t  csr;
        wctl_args_t wctl;
    } op_args_u;

    typedef struct packed {
        logic [UUID_BITS-1:0]   uuid;
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_BITS-1:0]     pc;
        logic [31:0]            instr;
    } fetch_data_t;

    typedef struct packed {
        ex_type_e           ex_type;
        logic [OP_BITS-1:0] op_type;
        op_args_u           op_args;
        logic               wb;
        logic [NR_BITS-1:0] rd;
        logic [NR_BITS-1:0] rs1;
        logic [NR_BITS-1:0] rs2;
    } dec_fields_t;

    typedef struct packed {
        logic [UUID_BITS-1:0]   uuid;
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_BITS-1:0]     pc;
        dec_fields_t            fields;
    } decode_data_t;

    typedef struct packed {
        logic [IMM_BITS-1:0] i_imm;
        logic [IMM_BITS-1:0] s_imm;
        logic [IMM_BITS-1:0] b_imm;
        logic [IMM_BITS-1:0] u_imm;
        logic [IMM_BITS-1:0] j_imm;
    } imm_set_t;

endpackage

// ==== source/imm_gen.sv ====
// Purely combinational; i_imm holds only shamt for OP-IMM shifts and the other formats are sign-extended
`timescale 1ns/10ps

module imm_gen (
    input  logic [31:0]          instr,
    output decode_pkg::imm_set_t imms
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_shift;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // SLLI, SRLI and SRAI keep funct7 in the upper immediate bits
    assign is_shift = (opcode == decode_pkg::OPC_I) && (funct3[1:0] == 2'b01);

    assign imms.i_imm = is_shift ? {27'b0, instr[24:20]} : {{20{instr[31]}}, instr[31:20]};
    assign imms.s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imms.b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imms.u_imm = {instr[31:12], 12'b0};
    assign imms.j_imm = {
        {11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0
    };

endmodule

// ==== source/func_tables.sv ====
// Combinational funct decode; invalid branch funct3 or system funct12 gives op code 0
`timescale 1ns/10ps

module func_tables (
    input  logic [31:0] instr,
    output logic [3:0]  alu_op,
    output logic [3:0]  br_op,
    output logic [3:0]  sys_op,
    output logic [3:0]  mul_op
);

    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic        alt;

    assign funct3  = instr[14:12];
    assign funct12 = instr[31:20];
    // funct7 bit 5 picks SUB and SRA
    assign alt     = instr[30];

    always_comb begin
        case (funct3)
            3'h0:    alu_op = (instr[5] && alt) ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'h1:    alu_op = decode_pkg::ALU_SLL;
            3'h2:    alu_op = decode_pkg::ALU_SLT;
            3'h3:    alu_op = decode_pkg::ALU_SLTU;
            3'h4:    alu_op = decode_pkg::ALU_XOR;
            3'h5:    alu_op = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'h6:    alu_op = decode_pkg::ALU_OR;
            default: alu_op = decode_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h0:    br_op = decode_pkg::BR_EQ;
            3'h1:    br_op = decode_pkg::BR_NE;
            3'h4:    br_op = decode_pkg::BR_LT;
            3'h5:    br_op = decode_pkg::BR_GE;
            3'h6:    br_op = decode_pkg::BR_LTU;
            3'h7:    br_op = decode_pkg::BR_GEU;
            default: br_op = '0;
        endcase
    end

    always_comb begin
        case (funct12)
            12'h000: sys_op = decode_pkg::BR_ECALL;
            12'h001: sys_op = decode_pkg::BR_EBREAK;
            12'h002: sys_op = decode_pkg::BR_URET;
            12'h102: sys_op = decode_pkg::BR_SRET;
            12'h302: sys_op = decode_pkg::BR_MRET;
            default: sys_op = '0;
        endcase
    end

    // MUL through REMU follow funct3 order
    assign mul_op = {1'b0, funct3};

endmodule

// ==== source/instr_decoder.sv ====
// Zero-latency RV32IM plus warp-control decode; unknown encodings give all-zero fields and no stall
`timescale 1ns/10ps

module instr_decoder (
    input  logic [31:0]             instr,
    output decode_pkg::dec_fields_t fields,
    output logic                    wstall
);

    decode_pkg::imm_set_t  imms;
    decode_pkg::op_args_u  args;
    logic [3:0]            alu_op;
    logic [3:0]            br_op;
    logic [3:0]            sys_op;
    logic [3:0]            mul_op;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic                  use_rd;
    logic                  use_rs1;
    logic                  use_rs2;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    imm_gen imm_gen_i (
        .instr (instr),
        .imms  (imms)
    );

    func_tables func_tables_i (
        .instr  (instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op),
        .mul_op (mul_op)
    );

    always_comb begin
        fields.ex_type = decode_pkg::EX_ALU;
        fields.op_type = '0;
        args           = '0;
        use_rd         = 1'b0;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        wstall         = 1'b0;

        case (opcode)
            decode_pkg::OPC_I: begin
                fields.op_type   = alu_op;
                args.alu.use_imm = 1'b1;
                args.alu.imm     = imms.i_imm;
                use_rd           = 1'b1;
                use_rs1          = 1'b1;
            end
            decode_pkg::OPC_R: begin
                if (instr[31:25] == decode_pkg::F7_MUL) begin
                    fields.op_type = mul_op;
                    args.alu.xtype = decode_pkg::MULDIV;
                end else begin
                    fields.op_type = alu_op;
                end
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                fields.op_type   = opcode[5] ? decode_pkg::ALU_LUI : decode_pkg::ALU_AUIPC;
                args.alu.use_pc  = ~opcode[5];
                args.alu.use_imm = 1'b1;
                args.alu.imm     = imms.u_imm;
                use_rd           = 1'b1;
            end
            decode_pkg::OPC_JAL: begin
                fields.op_type   = decode_pkg::BR_JAL;
                args.alu.xtype   = decode_pkg::BRANCH;
                args.alu.use_pc  = 1'b1;
                args.alu.use_imm = 1'b1;
                args.alu.imm     = imms.j_imm;
                use_rd           = 1'b1;
                wstall           = 1'b1;
            end
            decode_pkg::OPC_JALR: begin
                fields.op_type   = decode_pkg::BR_JALR;
                args.alu.xtype   = decode_pkg::BRANCH;
                args.alu.use_imm = 1'b1;
                args.alu.imm     = imms.i_imm;
                use_rd           = 1'b1;
                use_rs1          = 1'b1;
                wstall           = 1'b1;
            end
            decode_pkg::OPC_B: begin
                fields.op_type   = br_op;
                args.alu.xtype   = decode_pkg::BRANCH;
                args.alu.use_pc  = 1'b1;
                args.alu.use_imm = 1'b1;
                args.alu.imm     = imms.b_imm;
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
                wstall           = 1'b1;
            end
            decode_pkg::OPC_L, decode_pkg::OPC_S: begin
                fields.ex_type    = decode_pkg::EX_LSU;
                fields.op_type    = {opcode[5], funct3};
                args.lsu.is_store = opcode[5];
                args.lsu.offset   = opcode[5] ? imms.s_imm[11:0] : imms.i_imm[11:0];
                use_rd            = ~opcode[5];
                use_rs1           = 1'b1;
                use_rs2           = opcode[5];
            end
            decode_pkg::OPC_FENCE: begin
                fields.ex_type = decode_pkg::EX_LSU;
                fields.op_type = decode_pkg::LSU_FENCE;
            end
            decode_pkg::OPC_SYS: begin
                if (funct3[1:0] != 2'b00) begin
                    fields.ex_type   = decode_pkg::EX_SFU;
                    fields.op_type   = {2'b00, funct3[1:0]};
                    args.csr.addr    = instr[31:20];
                    args.csr.use_imm = funct3[2];
                    args.csr.imm     = funct3[2] ? rs1 : 5'd0;
                    use_rd           = 1'b1;
                    use_rs1          = ~funct3[2];
                    // Only FPU CSRs need the warp held
                    wstall           = (instr[31:20] <= decode_pkg::CSR_FCSR);
                end else begin
                    // ECALL, EBREAK and xRET redirect to pc + 4
                    fields.op_type   = sys_op;
                    args.alu.xtype   = decode_pkg::BRANCH;
                    args.alu.use_pc  = 1'b1;
                    args.alu.use_imm = 1'b1;
                    args.alu.imm     = 32'd4;
                    wstall           = 1'b1;
                end
            end
            decode_pkg::OPC_EXT1: begin
                if ((instr[31:25] == 7'h00) && (funct3 <= 3'h5)) begin
                    fields.ex_type = decode_pkg::EX_SFU;
                    use_rs1        = 1'b1;
                    wstall         = 1'b1;
                    case (funct3)
                        3'h0: fields.op_type = decode_pkg::SFU_TMC;
                        3'h1: begin
                            fields.op_type = decode_pkg::SFU_WSPAWN;
                            use_rs2        = 1'b1;
                        end
                        3'h2: begin
                            fields.op_type   = decode_pkg::SFU_SPLIT;
                            args.wctl.is_neg = rs2[0];
                            use_rd           = 1'b1;
                        end
                        3'h3: fields.op_type = decode_pkg::SFU_JOIN;
                        3'h4: begin
                            fields.op_type = decode_pkg::SFU_BAR;
                            use_rs2        = 1'b1;
                        end
                        default: begin
                            fields.op_type   = decode_pkg::SFU_PRED;
                            args.wctl.is_neg = rd[0];
                            use_rs2          = 1'b1;
                        end
                    endcase
                end
            end
            default: begin
            end
        endcase
    end

    assign fields.op_args = args;
    assign fields.rd      = use_rd ? rd : 5'd0;
    assign fields.rs1     = use_rs1 ? rs1 : 5'd0;
    assign fields.rs2     = use_rs2 ? rs2 : 5'd0;
    // x0 never takes a writeback
    assign fields.wb      = use_rd && (rd != 5'd0);

    // Every control transfer holds the warp
    assert property (@(instr) ((fields.ex_type == decode_pkg::EX_ALU) &&
        (fields.op_args.alu.xtype == decode_pkg::BRANCH)) |-> wstall);

endmodule

// ==== source/decode_buffer.sv ====
// One-entry pipe register, one cycle latency at full throughput; scheduler notice is unregistered
`timescale 1ns/10ps

module decode_buffer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  decode_pkg::fetch_data_t            in_data,
    input  decode_pkg::dec_fields_t            in_fields,
    input  logic                               in_wstall,
    output logic                               out_valid,
    input  logic                               out_ready,
    output decode_pkg::decode_data_t           out_data,
    output logic                               sched_valid,
    output logic [decode_pkg::NW_BITS-1:0]     sched_wid,
    output logic                               sched_wstall
);

    logic in_fire;

    assign in_ready = ~out_valid | out_ready;
    assign in_fire  = in_valid & in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data.uuid   <= in_data.uuid;
            out_data.wid    <= in_data.wid;
            out_data.tmask  <= in_data.tmask;
            out_data.pc     <= in_data.pc;
            out_data.fields <= in_fields;
        end
    end

    // Scheduler learns the stall decision in the accept cycle
    assign sched_valid  = in_fire;
    assign sched_wid    = in_data.wid;
    assign sched_wstall = in_wstall;

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

// ==== source/decode_stage.sv ====
// Decode stage top; decode_data lags fetch by one cycle, sched notice pulses with each fetch accept
`timescale 1ns/10ps

module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           fetch_valid,
    output logic                           fetch_ready,
    input  decode_pkg::fetch_data_t        fetch_data,
    output logic                           decode_valid,
    input  logic                           decode_ready,
    output decode_pkg::decode_data_t       decode_data,
    output logic                           sched_valid,
    output logic [decode_pkg::NW_BITS-1:0] sched_wid,
    output logic                           sched_wstall
);

    decode_pkg::dec_fields_t fields;
    logic                    wstall;

    instr_decoder instr_decoder_i (
        .instr  (fetch_data.instr),
        .fields (fields),
        .wstall (wstall)
    );

    decode_buffer decode_buffer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (fetch_valid),
        .in_ready     (fetch_ready),
        .in_data      (fetch_data),
        .in_fields    (fields),
        .in_wstall    (wstall),
        .out_valid    (decode_valid),
        .out_ready    (decode_ready),
        .out_data     (decode_data),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_wstall (sched_wstall)
    );

endmodule

// ==== verif/decode_vectors.svh ====
// Included inside decode_stage_tb after add_vec and the op_args view functions; uuid and pc come from the driver
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Columns: name, instr, wid, tmask, ex_type, op_type, op_args, wb, rd, rs1, rs2, stall
task automatic load_vectors();
    add_vec("addi_neg", 32'hfff10093, 0, 4'hf, 0, 0, alu_view(0, 0, 1, 32'hffffffff), 1, 1, 2, 0, 0);
    add_vec("addi_b30", 32'h40000093, 1, 4'h1, 0, 0, alu_view(0, 0, 1, 32'h400), 1, 1, 0, 0, 0);
    add_vec("srai", 32'h40335293, 2, 4'h3, 0, 7, alu_view(0, 0, 1, 32'd3), 1, 5, 6, 0, 0);
    add_vec("add", 32'h009403b3, 3, 4'h7, 0, 0, alu_view(0, 0, 0, 32'd0), 1, 7, 8, 9, 0);
    add_vec("sub", 32'h40c58533, 0, 4'h8, 0, 1, alu_view(0, 0, 0, 32'd0), 1, 10, 11, 12, 0);
    add_vec("sra", 32'h40f756b3, 1, 4'hf, 0, 7, alu_view(0, 0, 0, 32'd0), 1, 13, 14, 15, 0);
    add_vec("lui_neg", 32'h800000b7, 2, 4'h5, 0, 10, alu_view(0, 0, 1, 32'h80000000), 1, 1, 0, 0, 0);
    add_vec("auipc", 32'h12345117, 3, 4'ha, 0, 11, alu_view(0, 1, 1, 32'h12345000), 1, 2, 0, 0, 0);
    add_vec("mul", 32'h025201b3, 0, 4'hf, 0, 0, alu_view(2, 0, 0, 32'd0), 1, 3, 4, 5, 0);
    add_vec("divu", 32'h0283d333, 1, 4'hf, 0, 5, alu_view(2, 0, 0, 32'd0), 1, 6, 7, 8, 0);
    // Backward and forward branches
    add_vec("beq", 32'hfe208ce3, 2, 4'hf, 0, 0, alu_view(1, 1, 1, 32'hfffffff8), 0, 0, 1, 2, 1);
    add_vec("bgeu", 32'h0041f863, 3, 4'hc, 0, 5, alu_view(1, 1, 1, 32'd16), 0, 0, 3, 4, 1);
    add_vec("jal", 32'h001000ef, 0, 4'hf, 0, 6, alu_view(1, 1, 1, 32'h800), 1, 1, 0, 0, 1);
    add_vec("jal_x0", 32'hffdff06f, 1, 4'hf, 0, 6, alu_view(1, 1, 1, 32'hfffffffc), 0, 0, 0, 0, 1);
    add_vec("jalr", 32'h004280e7, 2, 4'hf, 0, 7, alu_view(1, 0, 1, 32'd4), 1, 1, 5, 0, 1);
    add_vec("ecall", 32'h00000073, 3, 4'hf, 0, 8, alu_view(1, 1, 1, 32'd4), 0, 0, 0, 0, 1);
    add_vec("mret", 32'h30200073, 0, 4'h1, 0, 12, alu_view(1, 1, 1, 32'd4), 0, 0, 0, 0, 1);
    add_vec("lw", 32'hffc32283, 1, 4'hf, 1, 2, lsu_view(0, 12'hffc), 1, 5, 6, 0, 0);
    add_vec("sw", 32'h00742423, 2, 4'hf, 1, 10, lsu_view(1, 12'h008), 0, 0, 8, 7, 0);
    add_vec("fence", 32'h0ff0000f, 3, 4'hf, 1, 15, 36'h0, 0, 0, 0, 0, 0);
    // CSR stall boundary sits at address 3
    add_vec("csrrw", 32'h300110f3, 0, 4'hf, 2, 1, csr_view(12'h300, 0, 0), 1, 1, 2, 0, 0);
    add_vec("csrrsi", 32'h0022e1f3, 1, 4'hf, 2, 2, csr_view(12'h002, 1, 5), 1, 3, 0, 0, 1);
    add_vec("csrrc", 32'h00323073, 2, 4'hf, 2, 3, csr_view(12'h003, 0, 0), 0, 0, 4, 0, 1);
    add_vec("csrrci", 32'h0041f2f3, 3, 4'h6, 2, 3, csr_view(12'h004, 1, 3), 1, 5, 0, 0, 0);
    add_vec("tmc", 32'h0000800b, 3, 4'hf, 2, 4, 36'h0, 0, 0, 1, 0, 1);
    add_vec("wspawn", 32'h0031100b, 0, 4'h3, 2, 5, 36'h0, 0, 0, 2, 3, 1);
    add_vec("split", 32'h0012a20b, 1, 4'hf, 2, 6, wctl_view(1), 1, 4, 5, 0, 1);
    add_vec("join", 32'h0003300b, 2, 4'hf, 2, 7, 36'h0, 0, 0, 6, 0, 1);
    add_vec("bar", 32'h0083c00b, 3, 4'hf, 2, 8, 36'h0, 0, 0, 7, 8, 1);
    add_vec("pred", 32'h00a4d08b, 0, 4'hf, 2, 9, wctl_view(1), 0, 0, 9, 10, 1);
    add_vec("nop", 32'h00000013, 1, 4'hf, 0, 0, alu_view(0, 0, 1, 32'd0), 0, 0, 0, 0, 0);
    add_vec("unknown", 32'hffffffff, 2, 4'hf, 0, 0, 36'h0, 0, 0, 0, 0, 0);
    add_vec("ext1_bad", 32'h0200800b, 3, 4'hf, 0, 0, 36'h0, 0, 0, 0, 0, 0);
endtask

`endif

// ==== verif/decode_stage_tb.sv ====
// Back-to-back fetches with random decode_ready stalls; at most 64 table entries, uuid is the index
`timescale 1ns/10ps

module decode_stage_tb;

    typedef struct {
        string                   name;
        logic [31:0]             instr;
        logic [1:0]              wid;
        logic [3:0]              tmask;
        decode_pkg::dec_fields_t fields;
        logic                    stall;
    } vector_t;

    logic                       clk;
    logic                       rst_n;
    logic                       fetch_valid;
    logic                       fetch_ready;
    decode_pkg::fetch_data_t    fetch_data;
    logic                       decode_valid;
    logic                       decode_ready;
    decode_pkg::decode_data_t   decode_data;
    logic                       sched_valid;
    logic [1:0]                 sched_wid;
    logic                       sched_wstall;

    vector_t     vecs[$];
    logic        sched_bad [0:63];
    int          num_vecs;
    int          out_count;
    int          sched_count;
    int          passed;
    int          failed;
    int          errors;
    logic [31:0] lcg_state;
    logic        fire_seen;
    logic [7:0]  fire_uuid;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // op_args layouts with the MSB first
    function automatic logic [35:0] alu_view(input int xtype, input int use_pc,
                                             input int use_imm, input logic [31:0] imm);
        return {xtype[1:0], use_pc[0], use_imm[0], imm};
    endfunction

    function automatic logic [35:0] lsu_view(input int is_store, input logic [11:0] offset);
        return {is_store[0], offset, 23'b0};
    endfunction

    function automatic logic [35:0] csr_view(input logic [11:0] addr, input int use_imm,
                                             input int imm);
        return {addr, use_imm[0], imm[4:0], 18'b0};
    endfunction

    function automatic logic [35:0] wctl_view(input int is_neg);
        return {is_neg[0], 35'b0};
    endfunction

    task automatic add_vec(input string name, input logic [31:0] instr, input int wid,
                           input logic [3:0] tmask, input int ex, input int op,
                           input logic [35:0] args, input int wb, input int rd,
                           input int rs1, input int rs2, input int stall);
        vector_t v;
        v.name   = name;
        v.instr  = instr;
        v.wid    = wid[1:0];
        v.tmask  = tmask;
        v.fields = {ex[1:0], op[3:0], args, wb[0], rd[4:0], rs1[4:0], rs2[4:0]};
        v.stall  = stall[0];
        vecs.push_back(v);
    endtask

    `include "decode_vectors.svh"

    decode_stage decode_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_data   (fetch_data),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode_data  (decode_data),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_wstall (sched_wstall)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    initial begin : driver
        logic [31:0] pc_word;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        for (int i = 0; i < 64; i++) begin
            sched_bad[i] = 1'b0;
        end
        load_vectors();
        num_vecs = vecs.size();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < num_vecs; i++) begin
            pc_word          = 32'h0000_1000 + i;
            fetch_valid      = 1'b1;
            fetch_data.uuid  = i[7:0];
            fetch_data.wid   = vecs[i].wid;
            fetch_data.tmask = vecs[i].tmask;
            fetch_data.pc    = pc_word[29:0];
            fetch_data.instr = vecs[i].instr;
            // Hold until accepted
            @(negedge clk);
            while (!fetch_ready) @(negedge clk);
            @(posedge clk);
            #1;
        end
        fetch_valid = 1'b0;
        fetch_data  = '0;
        wait (out_count == num_vecs);
        repeat (2) @(posedge clk);
        if (sched_count != num_vecs) begin
            $display("Scheduler notice pulsed %0d times for %0d fetches", sched_count, num_vecs);
            errors++;
        end
        $display("Tests: %0d passed, %0d failed, %0d other errors", passed, failed, errors);
        if (errors == 0 && failed == 0 && passed == num_vecs) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Random 0 to 3 cycles of decode_ready low before each ready cycle
    initial begin : back_pressure
        int hold;
        decode_ready = 1'b0;
        lcg_state    = 32'd77;
        @(posedge rst_n);
        forever begin
            lcg_state    = lcg_next(lcg_state);
            hold         = int'(lcg_state[17:16]);
            decode_ready = 1'b0;
            repeat (hold) begin
                @(posedge clk);
                #1;
            end
            decode_ready = 1'b1;
            @(posedge clk);
            #1;
        end
    end

    // Inputs move 1 ns after the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin : monitor
        decode_pkg::decode_data_t expected;
        logic [31:0]              exp_pc;
        if (!rst_n) begin
            fire_seen = 1'b0;
            if (decode_valid !== 1'b0) begin
                $display("decode_valid is high during reset");
                errors++;
            end
        end else begin
            if (decode_valid && !decode_ready && fetch_ready) begin
                $display("fetch_ready is high while the held item is stalled");
                errors++;
            end
            if ((!decode_valid || decode_ready) && !fetch_ready) begin
                $display("fetch_ready is low while the buffer can take an item");
                errors++;
            end
            if (fire_seen && (decode_valid !== 1'b1 || decode_data.uuid !== fire_uuid)) begin
                $display("Item %0d was not on decode_data one cycle after its fetch", fire_uuid);
                errors++;
            end
            fire_seen = fetch_valid && fetch_ready;
            fire_uuid = fetch_data.uuid;
            if (sched_valid) begin
                if (sched_count >= num_vecs) begin
                    $display("Scheduler notice pulsed with no fetch pending");
                    errors++;
                end else if (sched_wid !== vecs[sched_count].wid ||
                             sched_wstall !== vecs[sched_count].stall) begin
                    $display("FAIL %s sched: expected wid %0d stall %0b, actual wid %0d stall %0b",
                             vecs[sched_count].name, vecs[sched_count].wid,
                             vecs[sched_count].stall, sched_wid, sched_wstall);
                    sched_bad[sched_count] = 1'b1;
                end
                sched_count++;
            end
            if (decode_valid && decode_ready) begin
                if (out_count >= num_vecs) begin
                    $display("Decode output delivered an item that was never fetched");
                    errors++;
                end else begin
                    exp_pc   = 32'h0000_1000 + out_count;
                    expected = {out_count[7:0], vecs[out_count].wid, vecs[out_count].tmask,
                                exp_pc[29:0], vecs[out_count].fields};
                    if (decode_data !== expected) begin
                        $display("FAIL %s: expected %h, actual %h", vecs[out_count].name,
                                 expected, decode_data);
                        failed++;
                    end else if (sched_bad[out_count]) begin
                        $display("FAIL %s: scheduler notice was wrong", vecs[out_count].name);
                        failed++;
                    end else begin
                        $display("PASS %s", vecs[out_count].name);
                        passed++;
                    end
                end
                out_count++;
            end
        end
    end

    initial begin : watchdog
        wait (num_vecs > 0);
        repeat (num_vecs * 6 + 20) @(posedge clk);
        $display("Timeout: only %0d of %0d decode results arrived", out_count, num_vecs);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verif
source/decode_pkg.sv
source/imm_gen.sv
source/func_tables.sv
source/instr_decoder.sv
source/decode_buffer.sv
source/decode_stage.sv
verif/decode_stage_tb.sv

// ==== Makefile ====
TOP := decode_stage_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

obj_dir/V$(TOP): all.f source/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module decode_stage

clean:
	rm -rf obj_dir
